//--- fetch_pkg.sv
// fetch front end shared definitions: instruction width, opcodes, instruction word views
package fetch_pkg;

  parameter int ILEN = 32; // instruction word width

  // opcodes that predecode cares about
  parameter logic [6:0] OPC_BRANCH = 7'b1100011;
  parameter logic [6:0] OPC_JAL    = 7'b1101111;
  parameter logic [6:0] OPC_JALR   = 7'b1100111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_fields_t;

  // one fetched word, seen raw or split into fields
  typedef union packed {
    logic [ILEN-1:0] raw;
    instr_fields_t   fields;
  } instr_u;

endpackage

//--- ftq_if.sv
// fetch target queue interface toward the memory port and the packet assembler
`timescale 1ns/100ps

interface ftq_if #(
  parameter int PC_W = 32
) (
  input logic clk,
  input logic rst
);

  logic            issue_valid; // oldest target not yet sent to memory
  logic [PC_W-1:0] issue_pc;
  logic            issue_ready;
  logic            head_valid;  // oldest target still waiting for its word
  logic [PC_W-1:0] head_pc;
  logic            complete;    // retire the head

  modport queue (
    output issue_valid, issue_pc, head_valid, head_pc,
    input  issue_ready, complete
  );

  modport mem_port (
    input  issue_valid, issue_pc,
    output issue_ready
  );

  modport assemble (
    input  clk, rst, head_valid, head_pc,
    output complete
  );

endinterface

//--- fetch_pc_gen.sv
// next fetch address generator, sequential by 4 bytes, reloaded on redirect
`timescale 1ns/100ps

module fetch_pc_gen #(
  parameter int              PC_W     = 32,
  parameter logic [PC_W-1:0] RESET_PC = 32'h0000_1000
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            redirect_valid,
  input  logic [PC_W-1:0] redirect_pc,
  output logic            push_valid,
  input  logic            push_ready,
  output logic [PC_W-1:0] push_pc
);

  logic            active_q; // set once the first cycle out of reset has passed
  logic [PC_W-1:0] pc_q;
  logic            push_fire;

  assign push_valid = active_q && !redirect_valid;
  assign push_pc    = pc_q;
  assign push_fire  = push_valid && push_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q <= 1'b0;
      pc_q     <= RESET_PC;
    end else begin
      active_q <= 1'b1;
      if (redirect_valid) begin
        pc_q <= redirect_pc; // restart, push held off this cycle
      end else if (push_fire) begin
        pc_q <= pc_q + PC_W'(4);
      end
    end
  end

endmodule

//--- fetch_target_queue.sv
// fetch target queue holding in-order targets with per-entry issue tracking
`timescale 1ns/100ps

module fetch_target_queue #(
  parameter int PC_W      = 32,
  parameter int FTQ_DEPTH = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            flush,
  input  logic            push_valid,
  output logic            push_ready,
  input  logic [PC_W-1:0] push_pc,
  ftq_if.queue            ftq
);

  localparam int PTR_W = (FTQ_DEPTH > 1) ? $clog2(FTQ_DEPTH) : 1;

  logic [FTQ_DEPTH-1:0] valid_q;
  logic [FTQ_DEPTH-1:0] issued_q;
  logic [PC_W-1:0]      pc_q [FTQ_DEPTH]; // target addresses
  logic [PTR_W-1:0]     head_q;
  logic [PTR_W-1:0]     tail_q;
  logic [PTR_W:0]       count_q;

  logic             issue_found;
  logic [PTR_W-1:0] issue_idx;
  logic             push_fire;
  logic             pop_fire;
  logic             issue_fire;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(FTQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // walk from head to the first valid entry not yet sent out
  always_comb begin
    issue_found = 1'b0;
    issue_idx   = head_q;
    for (int i = 0; i < FTQ_DEPTH; i++) begin
      int idx;
      idx = (int'(head_q) + i) % FTQ_DEPTH;
      if (!issue_found && valid_q[idx] && !issued_q[idx]) begin
        issue_found = 1'b1;
        issue_idx   = PTR_W'(idx);
      end
    end
  end

  assign ftq.issue_valid = issue_found;
  assign ftq.issue_pc    = pc_q[issue_idx];
  assign ftq.head_valid  = valid_q[head_q];
  assign ftq.head_pc     = pc_q[head_q];

  assign pop_fire   = ftq.complete && valid_q[head_q];
  assign issue_fire = issue_found && ftq.issue_ready;
  assign push_ready = (count_q < (PTR_W+1)'(FTQ_DEPTH)) || pop_fire; // full but draining is ok
  assign push_fire  = push_valid && push_ready;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      valid_q  <= '0;
      issued_q <= '0;
      head_q   <= '0;
      tail_q   <= '0;
      count_q  <= '0;
    end else begin
      if (pop_fire) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= ptr_inc(head_q);
      end
      if (issue_fire) issued_q[issue_idx] <= 1'b1;
      if (push_fire) begin // tail may equal the popping head when full
        valid_q[tail_q]  <= 1'b1;
        issued_q[tail_q] <= 1'b0;
        tail_q           <= ptr_inc(tail_q);
      end
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_fire) pc_q[tail_q] <= push_pc;
  end

  // a push into a full queue would overwrite a live entry and break this count
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    (count_q <= (PTR_W+1)'(FTQ_DEPTH)) && ($countones(valid_q) == int'(count_q)));

  // assembler retires only a live head
  a_complete_head: assert property (@(posedge clk) disable iff (rst)
    ftq.complete |-> ftq.head_valid);

endmodule

//--- fetch_mem_port.sv
// instruction memory request port with credit limit, response FIFO and stale drop
`timescale 1ns/100ps

module fetch_mem_port #(
  parameter int PC_W      = 32,
  parameter int RSP_DEPTH = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         flush,
  ftq_if.mem_port                      ftq,
  output logic                         mem_req_valid,
  input  logic                         mem_req_ready,
  output logic [PC_W-1:0]              mem_req_addr,
  input  logic                         mem_rsp_valid,
  input  logic [fetch_pkg::ILEN-1:0]   mem_rsp_data,
  output logic                         rsp_avail,
  output fetch_pkg::instr_u            rsp_word,
  input  logic                         rsp_pop
);

  localparam int PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
  localparam int CNT_W = $clog2(RSP_DEPTH + 1);

  fetch_pkg::instr_u buf_q [RSP_DEPTH]; // response storage
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;   // words in the buffer
  logic [CNT_W-1:0]  out_q;   // reads in flight, stale ones included
  logic [CNT_W-1:0]  drop_q;  // in-flight reads from before the last redirect
  logic [CNT_W-1:0]  out_d;
  logic [CNT_W:0]    used;
  logic              credit;
  logic              req_fire;
  logic              dropping;
  logic              wr_en;
  logic              rd_en;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // a read may go out only if its word is sure to find room
  assign used          = {1'b0, out_q} + {1'b0, cnt_q};
  assign credit        = used < (CNT_W+1)'(RSP_DEPTH);
  assign mem_req_valid = ftq.issue_valid && credit;
  assign mem_req_addr  = ftq.issue_pc;
  assign ftq.issue_ready = mem_req_ready && credit;
  assign req_fire      = mem_req_valid && mem_req_ready;

  assign dropping = mem_rsp_valid && (drop_q != '0);
  assign wr_en    = mem_rsp_valid && !dropping && !flush;
  assign rd_en    = rsp_pop && (cnt_q != '0);
  assign out_d    = out_q + CNT_W'(req_fire) - CNT_W'(mem_rsp_valid);

  assign rsp_avail = cnt_q != '0;
  assign rsp_word  = buf_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      out_q    <= '0;
      drop_q   <= '0;
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      out_q <= out_d;
      if (flush) begin
        drop_q   <= out_d; // everything still in flight is now stale
        cnt_q    <= '0;
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end else begin
        if (dropping) drop_q <= drop_q - 1'b1;
        if (wr_en) wr_ptr_q <= ptr_inc(wr_ptr_q);
        if (rd_en) rd_ptr_q <= ptr_inc(rd_ptr_q);
        cnt_q <= cnt_q + CNT_W'(wr_en) - CNT_W'(rd_en);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) buf_q[wr_ptr_q].raw <= mem_rsp_data;
  end

  // memory must not answer reads that were never made
  a_rsp_has_req: assert property (@(posedge clk) disable iff (rst)
    mem_rsp_valid |-> out_q != '0);

  // credit keeps one slot per outstanding read
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> cnt_q < CNT_W'(RSP_DEPTH));

endmodule

//--- fetch_packet_assemble.sv
// fetch packet assembler: joins head target with its word and predecodes it
`timescale 1ns/100ps

module fetch_packet_assemble (
  ftq_if.assemble                     ftq,
  input  logic                        rsp_avail,
  input  fetch_pkg::instr_u           rsp_word,
  output logic                        rsp_pop,
  output logic                        out_valid,
  input  logic                        out_ready,
  output logic [$bits(ftq.head_pc)-1:0] out_pc,
  output logic [fetch_pkg::ILEN-1:0]  out_instr,
  output logic                        out_is_branch,
  output logic                        out_is_jump
);

  logic       fire;
  logic [6:0] opc;

  // words return in target order, so the oldest word belongs to the head
  assign out_valid = ftq.head_valid && rsp_avail;
  assign fire      = out_valid && out_ready;
  assign ftq.complete = fire;
  assign rsp_pop   = fire; // retire both sides together

  assign out_pc    = ftq.head_pc;
  assign out_instr = rsp_word.raw;
  assign opc       = rsp_word.fields.opcode;

  assign out_is_branch = opc == fetch_pkg::OPC_BRANCH;
  assign out_is_jump   = (opc == fetch_pkg::OPC_JAL) || (opc == fetch_pkg::OPC_JALR);

  // a stalled packet only changes by vanishing on a redirect
  a_out_stable: assert property (@(posedge ftq.clk) disable iff (ftq.rst)
    (out_valid && !out_ready) |=>
      (!out_valid || ($stable(out_pc) && $stable(out_instr))));

endmodule

//--- fetch_frontend_top.sv
// instruction fetch front end: pc generator, target queue, memory port, packet assembler
`timescale 1ns/100ps

module fetch_frontend_top #(
  parameter int              PC_W      = 32,
  parameter int              FTQ_DEPTH = 4,
  parameter int              RSP_DEPTH = 4,
  parameter logic [PC_W-1:0] RESET_PC  = 32'h0000_1000
) (
  input  logic                       clk,
  input  logic                       rst,
  output logic                       mem_req_valid,
  input  logic                       mem_req_ready,
  output logic [PC_W-1:0]            mem_req_addr,
  input  logic                       mem_rsp_valid,
  input  logic [fetch_pkg::ILEN-1:0] mem_rsp_data,
  input  logic                       redirect_valid,
  input  logic [PC_W-1:0]            redirect_pc,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [PC_W-1:0]            out_pc,
  output logic [fetch_pkg::ILEN-1:0] out_instr,
  output logic                       out_is_branch,
  output logic                       out_is_jump
);

  logic              push_valid;
  logic              push_ready;
  logic [PC_W-1:0]   push_pc;
  logic              rsp_avail;
  logic              rsp_pop;
  fetch_pkg::instr_u rsp_word;

  ftq_if #(.PC_W(PC_W)) ftq (.clk(clk), .rst(rst));

  fetch_pc_gen #(.PC_W(PC_W), .RESET_PC(RESET_PC)) u_pc_gen (
    .clk(clk), .rst(rst),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .push_valid(push_valid), .push_ready(push_ready), .push_pc(push_pc)
  );

  fetch_target_queue #(.PC_W(PC_W), .FTQ_DEPTH(FTQ_DEPTH)) u_ftq (
    .clk(clk), .rst(rst), .flush(redirect_valid),
    .push_valid(push_valid), .push_ready(push_ready), .push_pc(push_pc),
    .ftq(ftq.queue)
  );

  fetch_mem_port #(.PC_W(PC_W), .RSP_DEPTH(RSP_DEPTH)) u_mem_port (
    .clk(clk), .rst(rst), .flush(redirect_valid), .ftq(ftq.mem_port),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
    .mem_req_addr(mem_req_addr),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
    .rsp_avail(rsp_avail), .rsp_word(rsp_word), .rsp_pop(rsp_pop)
  );

  fetch_packet_assemble u_assemble (
    .ftq(ftq.assemble),
    .rsp_avail(rsp_avail), .rsp_word(rsp_word), .rsp_pop(rsp_pop),
    .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
    .out_instr(out_instr), .out_is_branch(out_is_branch), .out_is_jump(out_is_jump)
  );

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset source, 100 ns period with reset held for two cycles
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0; // released on a rising edge
  end

endmodule

//--- tb_top.sv
// fetch front end testbench with in-order random-latency memory and a reference PC model
`timescale 1ns/100ps

module tb_top;

  localparam int              PC_W     = 32;
  localparam logic [PC_W-1:0] RESET_PC = 32'h0000_1000;
  localparam int              N_SEQ    = 200;
  localparam int              N_RAND   = 300;
  localparam int              N_REDIR  = 300;
  localparam int              TIMEOUT  = 2 * 4 * (1 + N_SEQ + N_RAND + N_REDIR); // ~4 cycles/pkt

  logic                       clk;
  logic                       rst;
  logic                       mem_req_valid;
  logic                       mem_req_ready;
  logic [PC_W-1:0]            mem_req_addr;
  logic                       mem_rsp_valid;
  logic [fetch_pkg::ILEN-1:0] mem_rsp_data;
  logic                       redirect_valid;
  logic [PC_W-1:0]            redirect_pc;
  logic                       out_valid;
  logic                       out_ready;
  logic [PC_W-1:0]            out_pc;
  logic [fetch_pkg::ILEN-1:0] out_instr;
  logic                       out_is_branch;
  logic                       out_is_jump;

  logic [PC_W-1:0] pend_addr [$]; // reads accepted by memory in order
  int unsigned     pend_cyc [$];
  logic [PC_W-1:0] exp_pc = RESET_PC;
  int unsigned     cyc = 0;
  int              pkt_cnt = 0;
  int              redir_cnt = 0;
  int              errors = 0;
  int              flag_errs = 0;
  int              tests_failed = 0;
  bit              rand_rdy = 1'b0;
  bit              redir_en = 1'b0;
  string           test_name = "reset";

  tb_clk_gen u_clk (.clk(clk), .rst(rst));

  fetch_frontend_top #(.PC_W(PC_W), .FTQ_DEPTH(4), .RSP_DEPTH(4), .RESET_PC(RESET_PC)) UUT (
    .clk(clk), .rst(rst),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req_addr(mem_req_addr),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_instr(out_instr),
    .out_is_branch(out_is_branch), .out_is_jump(out_is_jump)
  );

  // memory contents with hashed upper bits and an opcode that cycles with the word index
  function automatic logic [fetch_pkg::ILEN-1:0] mem_word(input logic [PC_W-1:0] addr);
    logic [31:0] h;
    logic [6:0]  opc;
    h = addr * 32'h9e37_79b1;
    case (addr[3:2])
      2'd0:    opc = fetch_pkg::OPC_BRANCH;
      2'd1:    opc = fetch_pkg::OPC_JAL;
      2'd2:    opc = fetch_pkg::OPC_JALR;
      default: opc = 7'b0010011; // plain alu op
    endcase
    mem_word = {h[31:7], opc};
  endfunction

  function automatic logic [1:0] predecode(input fetch_pkg::instr_u w);
    predecode[1] = w.fields.opcode == fetch_pkg::OPC_BRANCH;
    predecode[0] = (w.fields.opcode == fetch_pkg::OPC_JAL) ||
                   (w.fields.opcode == fetch_pkg::OPC_JALR);
  endfunction

  task automatic check_pc(input string name, input logic [PC_W-1:0] exp,
                          input logic [PC_W-1:0] act);
    if (exp !== act) begin
      $display("ERR %s out_pc expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_instr(input string name, input fetch_pkg::instr_u exp,
                             input fetch_pkg::instr_u act);
    if (exp.raw !== act.raw) begin
      $display("ERR %s out_instr expected %h actual %h", name, exp.raw, act.raw);
      errors++;
    end
  endtask

  task automatic check_flags(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      $display("ERR %s branch/jump expected %b actual %b", name, exp, act);
      errors++;
      flag_errs++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  task automatic wait_packets(input int n);
    int target;
    target = pkt_cnt + n;
    wait (pkt_cnt >= target);
  endtask

  // input driver and in-order memory model
  initial begin
    int unsigned due;
    bit          armed;
    void'($urandom(32'h71f9d09a));
    due            = 0;
    armed          = 1'b0;
    mem_req_ready  = 1'b0;
    mem_rsp_valid  = 1'b0;
    mem_rsp_data   = '0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    out_ready      = 1'b0;
    forever begin
      @(posedge clk);
      out_ready     <= rand_rdy ? 1'($urandom % 2) : 1'b1;
      mem_req_ready <= rand_rdy ? ($urandom % 4 != 0) : 1'b1;
      if (redir_en && ($urandom % 20 == 0)) begin
        redirect_valid <= 1'b1;
        redirect_pc    <= 32'h0000_4000 + PC_W'(($urandom % 256) * 4);
      end else begin
        redirect_valid <= 1'b0;
      end
      if (pend_addr.size() != 0 && !armed) begin
        due   = pend_cyc[0] + 1 + $urandom % 5; // 1 to 5 cycles after acceptance
        armed = 1'b1;
      end
      if (armed && due <= cyc + 1) begin
        mem_rsp_valid <= 1'b1;
        mem_rsp_data  <= mem_word(pend_addr.pop_front());
        void'(pend_cyc.pop_front());
        armed = 1'b0;
      end else begin
        mem_rsp_valid <= 1'b0;
      end
    end
  end

  // sample handshakes mid-cycle where everything is settled
  always @(negedge clk) begin
    fetch_pkg::instr_u exp_word;
    if (rst === 1'b0) begin
      cyc++;
      if (cyc > TIMEOUT) begin
        $display("timeout: only %0d packets after %0d cycles", pkt_cnt, cyc);
        $display("Test failed");
        $finish;
      end else begin
        if (mem_req_valid && mem_req_ready) begin
          pend_addr.push_back(mem_req_addr);
          pend_cyc.push_back(cyc);
        end
        if (out_valid && out_ready) begin // older than a redirect in the same cycle
          exp_word.raw = mem_word(exp_pc);
          check_pc(test_name, exp_pc, out_pc);
          check_instr(test_name, exp_word, out_instr);
          check_flags(test_name, predecode(exp_word), {out_is_branch, out_is_jump});
          exp_pc = exp_pc + 4;
          pkt_cnt++;
        end
        if (redirect_valid) begin
          exp_pc = redirect_pc;
          redir_cnt++;
        end
      end
    end
  end

  initial begin
    int e0;
    wait (rst === 1'b0);
    @(negedge clk);
    e0 = errors;
    if (out_valid || mem_req_valid) begin
      $display("reset: out_valid or mem_req_valid high in the first cycle after reset");
      errors++;
    end
    wait_packets(1);
    report_test(test_name, e0);

    test_name = "sequential";
    e0 = errors;
    wait_packets(N_SEQ);
    report_test(test_name, e0);

    test_name = "random_backpressure";
    e0 = errors;
    rand_rdy = 1'b1;
    wait_packets(N_RAND);
    report_test(test_name, e0);

    test_name = "redirect";
    e0 = errors;
    redir_en = 1'b1;
    wait_packets(N_REDIR);
    if (redir_cnt == 0) begin
      $display("redirect: no redirect was driven during the test");
      errors++;
    end
    report_test(test_name, e0);

    report_test("predecode", errors - flag_errs);
    $display("5 tests, %0d failed, %0d errors, %0d packets, %0d redirects",
             tests_failed, errors, pkt_cnt, redir_cnt);
    if (errors == 0 && tests_failed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb.f
fetch_pkg.sv
ftq_if.sv
fetch_pc_gen.sv
fetch_target_queue.sv
fetch_mem_port.sv
fetch_packet_assemble.sv
fetch_frontend_top.sv
tb_clk_gen.sv
tb_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -Mdir obj_dir
	./obj_dir/Vtb_top > sim.log 2>&1 || { cat sim.log; exit 1; }
	cat sim.log
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log
